// ==== include/dbus_defines.svh ====
`ifndef DBUS_DEFINES_SVH
`define DBUS_DEFINES_SVH

// Cores on the bus, split evenly between the two memory ports
`define DBUS_NCORES 4

// Word address width, 256 words
`define DBUS_ADDRW 8

// Data word width
`define DBUS_XLEN 32

// One strobe bit per byte lane
`define DBUS_STRBW 4

`endif

// ==== hw/dbus_pkg.sv ====
`include "dbus_defines.svh"

package dbus_pkg;

    // Port A serves the lower half of the cores, port B the upper half
    localparam int dbus_half = `DBUS_NCORES / 2;
    localparam int dbus_core_w = $clog2(`DBUS_NCORES);
    // Index of a core within its own port
    localparam int dbus_slot_w = (dbus_half > 1) ? $clog2(dbus_half) : 1;

    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_LOAD  = 3'd1,
        OP_STORE = 3'd2,
        OP_LR    = 3'd3,
        OP_SC    = 3'd4
    } dbus_op_e;

    typedef struct packed {
        dbus_op_e                op;
        logic [`DBUS_ADDRW-1:0]  addr;
        logic [`DBUS_XLEN-1:0]   wdata;
        logic [`DBUS_STRBW-1:0]  strb;
    } dbus_req_t;

    typedef struct packed {
        logic                    valid;
        logic [dbus_core_w-1:0]  core;
    } dbus_grant_t;

    typedef struct packed {
        logic                    re;
        logic                    we;
        logic [`DBUS_ADDRW-1:0]  addr;
        logic [`DBUS_XLEN-1:0]   wdata;
        logic [`DBUS_STRBW-1:0]  strb;
    } dbus_mem_cmd_t;

    // Return info, lines up with the registered memory read data
    typedef struct packed {
        logic                    valid;
        logic [dbus_core_w-1:0]  core;
        logic                    is_sc;
        logic                    sc_ok;
    } dbus_ret_t;

endpackage

// ==== hw/dbus_req_hold.sv ====
`include "dbus_defines.svh"

module dbus_req_hold (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    input  dbus_pkg::dbus_req_t [`DBUS_NCORES-1:0]  req_i,
    input  logic [`DBUS_NCORES-1:0]                 wait_i,
    output dbus_pkg::dbus_req_t [`DBUS_NCORES-1:0]  eff_req_o,
    output logic [`DBUS_NCORES-1:0]                 stall_o
);
    import dbus_pkg::*;

    logic [`DBUS_NCORES-1:0] pend_q;
    dbus_req_t [`DBUS_NCORES-1:0] hold_q;

    // A core stays pending for as long as the arbiter keeps it waiting
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pend_q <= '0;
        end else begin
            pend_q <= wait_i;
        end
    end

    // Capture only on the first lost cycle, the live input is
    // ignored afterwards
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `DBUS_NCORES; i++) begin
            if (wait_i[i] && !pend_q[i]) begin
                hold_q[i] <= req_i[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `DBUS_NCORES; i++) begin
            if (pend_q[i]) begin
                eff_req_o[i] = hold_q[i];
            end else begin
                eff_req_o[i] = req_i[i];
            end
        end
    end

    // Pending flag doubles as the registered stall
    assign stall_o = pend_q;

endmodule

// ==== hw/dbus_arbiter.sv ====
`include "dbus_defines.svh"

module dbus_arbiter (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    input  dbus_pkg::dbus_req_t [`DBUS_NCORES-1:0]  eff_req_i,
    output dbus_pkg::dbus_grant_t                   grant_a_o,
    output dbus_pkg::dbus_grant_t                   grant_b_o,
    output logic [`DBUS_NCORES-1:0]                 wait_o
);
    import dbus_pkg::*;

    logic [dbus_slot_w-1:0]  ptr_a_q;
    logic [dbus_slot_w-1:0]  ptr_b_q;
    logic [`DBUS_NCORES-1:0] active;
    logic [`DBUS_NCORES-1:0] granted;
    dbus_grant_t             pick_a;
    dbus_grant_t             pick_b;
    logic                    same_addr;

    // First requester at or after the pointer, within one port
    function automatic dbus_grant_t rr_pick(
        input logic [dbus_half-1:0]   reqs,
        input logic [dbus_slot_w-1:0] ptr,
        input logic [dbus_core_w-1:0] base
    );
        dbus_grant_t            g;
        logic [dbus_slot_w-1:0] idx;
        g = '0;
        for (int k = 0; k < dbus_half; k++) begin
            idx = ptr + dbus_slot_w'(k);
            if (reqs[idx] && !g.valid) begin
                g.valid = 1'b1;
                g.core  = base + dbus_core_w'(idx);
            end
        end
        return g;
    endfunction

    always_comb begin
        for (int i = 0; i < `DBUS_NCORES; i++) begin
            active[i] = (eff_req_i[i].op != OP_NONE);
        end
    end

    assign pick_a = rr_pick(active[dbus_half-1:0], ptr_a_q, '0);
    assign pick_b = rr_pick(active[`DBUS_NCORES-1:dbus_half], ptr_b_q,
                            dbus_core_w'(dbus_half));

    // Port A has priority on a shared word
    assign same_addr = pick_a.valid && pick_b.valid &&
                       (eff_req_i[pick_a.core].addr == eff_req_i[pick_b.core].addr);

    always_comb begin
        grant_a_o = pick_a;
        grant_b_o = pick_b;
        if (same_addr) begin
            grant_b_o.valid = 1'b0;
        end
    end

    always_comb begin
        granted = '0;
        if (grant_a_o.valid) begin
            granted[grant_a_o.core] = 1'b1;
        end
        if (grant_b_o.valid) begin
            granted[grant_b_o.core] = 1'b1;
        end
    end

    assign wait_o = active & ~granted;

    // Pointers move one past the final winner of each port
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ptr_a_q <= '0;
            ptr_b_q <= '0;
        end else begin
            if (grant_a_o.valid) begin
                ptr_a_q <= grant_a_o.core[dbus_slot_w-1:0] + dbus_slot_w'(1);
            end
            if (grant_b_o.valid) begin
                ptr_b_q <= grant_b_o.core[dbus_slot_w-1:0] + dbus_slot_w'(1);
            end
        end
    end

endmodule

// ==== hw/dbus_access_ctrl.sv ====
`include "dbus_defines.svh"

module dbus_access_ctrl (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    input  dbus_pkg::dbus_req_t [`DBUS_NCORES-1:0]  eff_req_i,
    input  dbus_pkg::dbus_grant_t                   grant_a_i,
    input  dbus_pkg::dbus_grant_t                   grant_b_i,
    output dbus_pkg::dbus_mem_cmd_t                 cmd_a_o,
    output dbus_pkg::dbus_mem_cmd_t                 cmd_b_o,
    output dbus_pkg::dbus_ret_t                     ret_a_o,
    output dbus_pkg::dbus_ret_t                     ret_b_o
);
    import dbus_pkg::*;

    logic [`DBUS_NCORES-1:0]                  resv_valid_q;
    logic [`DBUS_NCORES-1:0]                  resv_valid_d;
    logic [`DBUS_NCORES-1:0][`DBUS_ADDRW-1:0] resv_addr_q;
    logic [`DBUS_NCORES-1:0][`DBUS_ADDRW-1:0] resv_addr_d;
    dbus_req_t                                win_a;
    dbus_req_t                                win_b;

    // SC writes only while its own reservation still covers the word
    function automatic dbus_mem_cmd_t to_cmd(
        input dbus_grant_t            g,
        input dbus_req_t              r,
        input logic                   rv,
        input logic [`DBUS_ADDRW-1:0] ra
    );
        dbus_mem_cmd_t c;
        c       = '0;
        c.addr  = r.addr;
        c.wdata = r.wdata;
        c.strb  = r.strb;
        if (g.valid) begin
            case (r.op)
                OP_LOAD, OP_LR: c.re = 1'b1;
                OP_STORE:       c.we = 1'b1;
                OP_SC:          c.we = rv && (ra == r.addr);
                default:        c.re = 1'b0;
            endcase
        end
        return c;
    endfunction

    function automatic dbus_ret_t to_ret(
        input dbus_grant_t   g,
        input dbus_req_t     r,
        input dbus_mem_cmd_t c
    );
        dbus_ret_t t;
        t.valid = g.valid;
        t.core  = g.core;
        t.is_sc = g.valid && (r.op == OP_SC);
        t.sc_ok = t.is_sc && c.we;
        return t;
    endfunction

    assign win_a = eff_req_i[grant_a_i.core];
    assign win_b = eff_req_i[grant_b_i.core];

    assign cmd_a_o = to_cmd(grant_a_i, win_a, resv_valid_q[grant_a_i.core],
                            resv_addr_q[grant_a_i.core]);
    assign cmd_b_o = to_cmd(grant_b_i, win_b, resv_valid_q[grant_b_i.core],
                            resv_addr_q[grant_b_i.core]);

    // Ports never touch the same word in one cycle, so clears and sets
    // cannot collide
    always_comb begin
        resv_valid_d = resv_valid_q;
        resv_addr_d  = resv_addr_q;
        for (int i = 0; i < `DBUS_NCORES; i++) begin
            if ((cmd_a_o.we && (resv_addr_q[i] == cmd_a_o.addr)) ||
                (cmd_b_o.we && (resv_addr_q[i] == cmd_b_o.addr))) begin
                resv_valid_d[i] = 1'b0;
            end
        end
        if (grant_a_i.valid && (win_a.op == OP_LR)) begin
            resv_valid_d[grant_a_i.core] = 1'b1;
            resv_addr_d[grant_a_i.core]  = win_a.addr;
        end
        if (grant_b_i.valid && (win_b.op == OP_LR)) begin
            resv_valid_d[grant_b_i.core] = 1'b1;
            resv_addr_d[grant_b_i.core]  = win_b.addr;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            resv_valid_q <= '0;
            ret_a_o      <= '0;
            ret_b_o      <= '0;
        end else begin
            resv_valid_q <= resv_valid_d;
            ret_a_o      <= to_ret(grant_a_i, win_a, cmd_a_o);
            ret_b_o      <= to_ret(grant_b_i, win_b, cmd_b_o);
        end
    end

    always_ff @(posedge clk_i) begin
        resv_addr_q <= resv_addr_d;
    end

endmodule

// ==== hw/dbus_dmem.sv ====
`include "dbus_defines.svh"

module dbus_dmem (
    input  logic                     clk_i,
    input  dbus_pkg::dbus_mem_cmd_t  cmd_a_i,
    input  dbus_pkg::dbus_mem_cmd_t  cmd_b_i,
    output logic [`DBUS_XLEN-1:0]    rdata_a_o,
    output logic [`DBUS_XLEN-1:0]    rdata_b_o
);

    logic [`DBUS_XLEN-1:0] mem [2**`DBUS_ADDRW];

    // Byte lanes are written independently
    always_ff @(posedge clk_i) begin
        for (int b = 0; b < `DBUS_STRBW; b++) begin
            if (cmd_a_i.we && cmd_a_i.strb[b]) begin
                mem[cmd_a_i.addr][8*b +: 8] <= cmd_a_i.wdata[8*b +: 8];
            end
            if (cmd_b_i.we && cmd_b_i.strb[b]) begin
                mem[cmd_b_i.addr][8*b +: 8] <= cmd_b_i.wdata[8*b +: 8];
            end
        end
    end

    // Registered reads, one cycle latency
    always_ff @(posedge clk_i) begin
        if (cmd_a_i.re) begin
            rdata_a_o <= mem[cmd_a_i.addr];
        end
        if (cmd_b_i.re) begin
            rdata_b_o <= mem[cmd_b_i.addr];
        end
    end

endmodule

// ==== hw/dbus_resp_route.sv ====
`include "dbus_defines.svh"

module dbus_resp_route (
    input  dbus_pkg::dbus_ret_t                         ret_a_i,
    input  dbus_pkg::dbus_ret_t                         ret_b_i,
    input  logic [`DBUS_XLEN-1:0]                       rdata_a_i,
    input  logic [`DBUS_XLEN-1:0]                       rdata_b_i,
    output logic [`DBUS_NCORES-1:0][`DBUS_XLEN-1:0]     rdata_o
);
    import dbus_pkg::*;

    // SC reports zero on success and one on failure
    function automatic logic [`DBUS_XLEN-1:0] port_word(
        input dbus_ret_t             r,
        input logic [`DBUS_XLEN-1:0] d
    );
        if (r.is_sc) begin
            return {{(`DBUS_XLEN-1){1'b0}}, ~r.sc_ok};
        end
        return d;
    endfunction

    always_comb begin
        for (int i = 0; i < `DBUS_NCORES; i++) begin
            if (ret_a_i.valid && (ret_a_i.core == dbus_core_w'(i))) begin
                rdata_o[i] = port_word(ret_a_i, rdata_a_i);
            end else if (ret_b_i.valid && (ret_b_i.core == dbus_core_w'(i))) begin
                rdata_o[i] = port_word(ret_b_i, rdata_b_i);
            end else begin
                rdata_o[i] = '0;
            end
        end
    end

endmodule

// ==== hw/dbus_top.sv ====
`include "dbus_defines.svh"

module dbus_top (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    input  dbus_pkg::dbus_req_t [`DBUS_NCORES-1:0]  req_i,
    output logic [`DBUS_NCORES-1:0]                 stall_o,
    output logic [`DBUS_NCORES-1:0][`DBUS_XLEN-1:0] rdata_o
);
    import dbus_pkg::*;

    dbus_req_t [`DBUS_NCORES-1:0] eff_req;
    logic [`DBUS_NCORES-1:0]      wait_req;
    dbus_grant_t                  grant_a;
    dbus_grant_t                  grant_b;
    dbus_mem_cmd_t                cmd_a;
    dbus_mem_cmd_t                cmd_b;
    dbus_ret_t                    ret_a;
    dbus_ret_t                    ret_b;
    logic [`DBUS_XLEN-1:0]        rdata_a;
    logic [`DBUS_XLEN-1:0]        rdata_b;

    dbus_req_hold dbus_req_hold_inst (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (req_i),
        .wait_i    (wait_req),
        .eff_req_o (eff_req),
        .stall_o   (stall_o)
    );

    dbus_arbiter dbus_arbiter_inst (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .eff_req_i (eff_req),
        .grant_a_o (grant_a),
        .grant_b_o (grant_b),
        .wait_o    (wait_req)
    );

    dbus_access_ctrl dbus_access_ctrl_inst (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .eff_req_i (eff_req),
        .grant_a_i (grant_a),
        .grant_b_i (grant_b),
        .cmd_a_o   (cmd_a),
        .cmd_b_o   (cmd_b),
        .ret_a_o   (ret_a),
        .ret_b_o   (ret_b)
    );

    dbus_dmem dbus_dmem_inst (
        .clk_i     (clk_i),
        .cmd_a_i   (cmd_a),
        .cmd_b_i   (cmd_b),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    dbus_resp_route dbus_resp_route_inst (
        .ret_a_i   (ret_a),
        .ret_b_i   (ret_b),
        .rdata_a_i (rdata_a),
        .rdata_b_i (rdata_b),
        .rdata_o   (rdata_o)
    );

endmodule

// ==== tb/dbus_top_tb.sv ====
`include "dbus_defines.svh"

module dbus_top_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import dbus_pkg::*;

    localparam int WAIT_MAX = 16;
    localparam int RAND_OPS = 40;
    // Rough cycle count of the memory fill and all tests
    localparam int TEST_CYC = 2**`DBUS_ADDRW + 4 + 8 + 4 * 8 + 12 + 24 +
                              RAND_OPS * (WAIT_MAX + 4);
    localparam int TIMEOUT_NS = (TEST_CYC + 200) * 10;

    logic                                    clk = 1'b0;
    logic                                    reset;
    dbus_req_t [`DBUS_NCORES-1:0]            req;
    logic [`DBUS_NCORES-1:0]                 stall;
    logic [`DBUS_NCORES-1:0][`DBUS_XLEN-1:0] rdata;

    // Reference memory and reservation model
    logic [`DBUS_XLEN-1:0]  ref_mem [2**`DBUS_ADDRW];
    logic [`DBUS_NCORES-1:0] resv_v;
    logic [`DBUS_ADDRW-1:0] resv_a [`DBUS_NCORES];
    logic [`DBUS_XLEN-1:0]  exp_q [`DBUS_NCORES];
    int                     res_cyc [`DBUS_NCORES];
    int                     ptr_a;
    int                     cyc = 0;
    int                     errors = 0;
    int                     n_pass = 0;
    int                     n_fail = 0;

    dbus_top dbus_top_inst (
        .clk_i   (clk),
        .reset_i (reset),
        .req_i   (req),
        .stall_o (stall),
        .rdata_o (rdata)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Result words are checked mid-cycle away from both edges
    for (genvar g = 0; g < `DBUS_NCORES; g++) begin : g_rdata_chk
        assert property (@(negedge clk) (res_cyc[g] == cyc) |-> (rdata[g] == exp_q[g]))
        else begin
            errors++;
            $display("FAILED rdata_o[%0d]: got %h, expected %h", g, rdata[g], exp_q[g]);
        end
    end

    function automatic void write_word(
        input logic [`DBUS_ADDRW-1:0] a,
        input logic [`DBUS_XLEN-1:0]  d,
        input logic [`DBUS_STRBW-1:0] s
    );
        for (int b = 0; b < `DBUS_STRBW; b++) begin
            if (s[b]) begin
                ref_mem[a][8*b +: 8] = d[8*b +: 8];
            end
        end
        // Any write kills every reservation on the word
        for (int i = 0; i < `DBUS_NCORES; i++) begin
            if (resv_a[i] == a) begin
                resv_v[i] = 1'b0;
            end
        end
    endfunction

    // Runs in the result cycle, one cycle after the request was served
    function automatic void record_result(input int c, input dbus_req_t r);
        logic ok;
        if (c < dbus_half) begin
            ptr_a = (c + 1) % dbus_half;
        end
        case (r.op)
            OP_LOAD: exp_q[c] = ref_mem[r.addr];
            OP_LR: begin
                exp_q[c]  = ref_mem[r.addr];
                resv_v[c] = 1'b1;
                resv_a[c] = r.addr;
            end
            OP_STORE: write_word(r.addr, r.wdata, r.strb);
            OP_SC: begin
                ok = resv_v[c] && (resv_a[c] == r.addr);
                if (ok) begin
                    write_word(r.addr, r.wdata, r.strb);
                end
                exp_q[c] = ok ? 32'd0 : 32'd1;
            end
            default: ;
        endcase
        if (r.op != OP_STORE) begin
            res_cyc[c] = cyc;
        end
    endfunction

    task automatic issue(
        input int                     c,
        input dbus_op_e               op,
        input logic [`DBUS_ADDRW-1:0] a,
        input logic [`DBUS_XLEN-1:0]  d,
        input logic [`DBUS_STRBW-1:0] s
    );
        dbus_req_t r;
        int        n;
        r = '{op: op, addr: a, wdata: d, strb: s};
        n = 0;
        req[c] = r;
        @(posedge clk);
        #1;
        req[c] = '0;
        while (stall[c] && (n < WAIT_MAX)) begin
            n++;
            @(posedge clk);
            #1;
        end
        assert (!stall[c]) else begin
            errors++;
            $display("Core %0d request still stalled after %0d cycles", c, n);
        end
        if (!stall[c]) begin
            record_result(c, r);
        end
    endtask

    // Stall vector one cycle after a request cycle
    task automatic expect_stall(input logic [`DBUS_NCORES-1:0] e);
        @(posedge clk);
        #1;
        assert (stall == e) else begin
            errors++;
            $display("FAILED stall_o: got %h, expected %h", stall, e);
        end
    endtask

    task automatic random_stream(input int c);
        dbus_op_e op;
        for (int k = 0; k < RAND_OPS; k++) begin
            repeat ($urandom_range(0, 2)) begin
                @(posedge clk);
                #1;
            end
            op = dbus_op_e'(3'($urandom_range(1, 4)));
            issue(c, op, 8'(8'h80 + $urandom_range(0, 3)), $urandom, 4'($urandom));
        end
    endtask

    // Every word gets a known value built from its whole address
    task automatic fill_memory();
        logic [`DBUS_ADDRW-1:0] a;
        for (int i = 0; i < 2**`DBUS_ADDRW; i++) begin
            a = i[`DBUS_ADDRW-1:0];
            issue(0, OP_STORE, a, {~a, a ^ 8'h5a, a, 8'h0f + a}, 4'hf);
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        @(posedge clk);
        #1;
        if (errors == err_before) begin
            n_pass++;
            $display("test %-12s pass", name);
        end else begin
            n_fail++;
            $display("test %-12s fail, %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, a request never completed", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int                    e0;
        int                    w;
        logic [`DBUS_ADDRW-1:0] a;
        logic [`DBUS_XLEN-1:0]  d;
        void'($urandom(36));
        reset  = 1'b1;
        req    = '0;
        resv_v = '0;
        ptr_a  = 0;
        for (int i = 0; i < 2**`DBUS_ADDRW; i++) begin
            ref_mem[i] = '0;
        end
        for (int i = 0; i < `DBUS_NCORES; i++) begin
            res_cyc[i] = -1;
            resv_a[i]  = '0;
            exp_q[i]   = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        e0 = errors;
        assert (stall == '0) else begin
            errors++;
            $display("FAILED stall_o: got %h, expected 0", stall);
        end
        assert (rdata == '0) else begin
            errors++;
            $display("FAILED rdata_o: got %h, expected 0", rdata);
        end
        finish_test("reset", e0);

        e0 = errors;
        fill_memory();
        issue(0, OP_STORE, 8'h10, 32'h11223344, 4'hf);
        issue(0, OP_STORE, 8'h10, 32'haabbccdd, 4'b0101);
        issue(0, OP_LOAD, 8'h10, '0, '0);
        finish_test("byte_merge", e0);

        // Core 0 stores while core 1 loads the same word, then the winner goes again alone
        e0 = errors;
        for (int k = 0; k < 4; k++) begin
            w = ptr_a;
            a = 8'(8'h30 + k);
            d = $urandom;
            fork
                issue(0, OP_STORE, a, d, 4'hf);
                issue(1, OP_LOAD, a, '0, '0);
                expect_stall(4'(1 << (1 - w)));
            join
            $display("  round %0d won by core %0d", k, w);
            issue(w, OP_LOAD, a, '0, '0);
        end
        finish_test("round_robin", e0);

        e0 = errors;
        issue(0, OP_STORE, 8'h50, $urandom, 4'hf);
        issue(0, OP_STORE, 8'h51, $urandom, 4'hf);
        fork
            issue(0, OP_LOAD, 8'h50, '0, '0);
            issue(2, OP_LOAD, 8'h50, '0, '0);
            expect_stall(4'b0100);
        join
        fork
            issue(0, OP_LOAD, 8'h50, '0, '0);
            issue(2, OP_LOAD, 8'h51, '0, '0);
            expect_stall(4'b0000);
        join
        finish_test("cross_port", e0);

        e0 = errors;
        issue(1, OP_LR, 8'h60, '0, '0);
        issue(1, OP_SC, 8'h60, $urandom, 4'hf);
        issue(1, OP_LOAD, 8'h60, '0, '0);
        issue(3, OP_LR, 8'h61, '0, '0);
        issue(0, OP_STORE, 8'h61, $urandom, 4'h3);
        issue(3, OP_SC, 8'h61, $urandom, 4'hf);
        issue(3, OP_LOAD, 8'h61, '0, '0);
        finish_test("lr_sc", e0);

        e0 = errors;
        fork
            random_stream(0);
            random_stream(1);
            random_stream(2);
            random_stream(3);
        join
        finish_test("random", e0);

        $display("Tests passed: %0d, failed: %0d, check errors: %0d", n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== dbus_top.f ====
+incdir+include
hw/dbus_pkg.sv
hw/dbus_req_hold.sv
hw/dbus_arbiter.sv
hw/dbus_access_ctrl.sv
hw/dbus_dmem.sv
hw/dbus_resp_route.sv
hw/dbus_top.sv
tb/dbus_top_tb.sv

// ==== Makefile ====
TB_TOP := dbus_top_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f dbus_top.f --top-module dbus_top

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f dbus_top.f \
		--top-module $(TB_TOP) -Mdir obj_dir -o sim_$(TB_TOP)
	./obj_dir/sim_$(TB_TOP) | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
